// ==== verilog.f ====
common/udp_bridge_pkg.sv
rtl/cfg_regs.sv
rx/udp_rx_demux.sv
tx/udp_tx_header.sv
rtl/udp_app_bridge.sv
dv/udp_app_bridge_asserts.sv
dv/udp_app_bridge_tb.sv

// ==== dv/udp_app_bridge_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the UDP application bridge
// register access, receive steering, transmit headers, back-pressure
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module udp_app_bridge_tb;

    localparam int          TIMEOUT    = 50;
    localparam logic [31:0] LOCAL_IP   = 32'hC0A8_0180;
    localparam logic [31:0] GATEWAY_IP = 32'hC0A8_0101;

    logic        clk;
    logic        rst;
    logic        rx_hdr_valid;
    logic        rx_hdr_ready;
    logic [15:0] rx_dest_port;
    logic [31:0] rx_source_ip;
    logic [63:0] rx_payload_data;
    logic [7:0]  rx_payload_keep;
    logic        rx_payload_valid;
    logic        rx_payload_ready;
    logic        rx_payload_last;
    logic        rx_payload_user;
    logic [63:0] m00_data;
    logic [7:0]  m00_keep;
    logic        m00_valid;
    logic        m00_ready;
    logic        m00_last;
    logic        m00_user;
    logic [63:0] m01_data;
    logic [7:0]  m01_keep;
    logic        m01_valid;
    logic        m01_ready;
    logic        m01_last;
    logic        m01_user;
    logic [63:0] s00_data;
    logic [7:0]  s00_keep;
    logic        s00_valid;
    logic        s00_ready;
    logic        s00_last;
    logic [1:0]  s00_channel;
    logic        tx_hdr_valid;
    logic        tx_hdr_ready;
    logic [15:0] tx_source_port;
    logic [15:0] tx_dest_port;
    logic [31:0] tx_source_ip;
    logic [31:0] tx_dest_ip;
    logic [63:0] tx_payload_data;
    logic [7:0]  tx_payload_keep;
    logic        tx_payload_valid;
    logic        tx_payload_ready;
    logic        tx_payload_last;
    logic        cfg_wr_en;
    logic [1:0]  cfg_addr;
    logic [31:0] cfg_wr_data;
    logic [31:0] cfg_rd_data;
    logic [31:0] local_ip;
    logic [31:0] gateway_ip;

    logic [15:0]  lfsr;
    logic [31:0]  last_src_ip;
    int           value_errors;
    int           timeouts;
    // expected transfers per stream, fields packed low to high
    logic [127:0] exp_m00[$];
    logic [127:0] exp_m01[$];
    logic [127:0] exp_tx_hdr[$];
    logic [127:0] exp_tx_pay[$];

    udp_app_bridge dut0 (.*);

    always #10 clk = ~clk;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic random_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v[i] = lfsr[0];
        end
    endtask

    // channel code to UDP port
    function automatic logic [15:0] port_for_channel(input logic [1:0] chan);
        case (chan)
            2'd0:    return 16'd10000;
            2'd1:    return 16'd10001;
            2'd2:    return 16'd10002;
            default: return 16'd0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [127:0] want,
                               input logic [127:0] got);
        assert (got === want) else begin
            value_errors++;
            $display("error %s expected %0h got %0h", name, want, got);
        end
    endtask

    task automatic check_beat(input string name, ref logic [127:0] q[$],
                              input logic [127:0] got);
        logic [127:0] want;
        if (q.size() == 0) begin
            value_errors++;
            $display("unexpected transfer on %s", name);
        end else begin
            want = q.pop_front();
            check_value(name, want, got);
        end
    endtask

    task automatic report_leftover(input string name, input int n);
        if (n != 0) begin
            value_errors++;
            $display("%0d expected transfers never seen on %s", n, name);
        end
    endtask

    function automatic logic handshake(input int sel);
        case (sel)
            0:       return rx_hdr_valid && rx_hdr_ready;
            1:       return rx_payload_valid && rx_payload_ready;
            default: return s00_valid && s00_ready;
        endcase
    endfunction

    // called on a falling edge, returns on the falling edge after the transfer
    task automatic wait_handshake(input int sel, input string what);
        int n;
        n = 0;
        @(posedge clk);
        while (!handshake(sel) && n < TIMEOUT) begin
            n++;
            @(posedge clk);
        end
        if (!handshake(sel)) begin
            timeouts++;
            $display("timeout waiting for %s", what);
        end
        @(negedge clk);
    endtask

    task automatic read_back(input logic [1:0] addr, input logic [31:0] want);
        cfg_addr = addr;
        @(negedge clk);
        check_value("cfg_rd_data", want, cfg_rd_data);
    endtask

    // stall_at picks a beat that waits 3 cycles on its sink's ready, -1 for none
    task automatic send_rx_frame(input logic [15:0] port, input logic [31:0] src_ip,
                                 input int beats, input int stall_at);
        logic [63:0]  data;
        logic [63:0]  bits;
        logic [127:0] beat;
        rx_hdr_valid = 1'b1;
        rx_dest_port = port;
        rx_source_ip = src_ip;
        wait_handshake(0, "rx header");
        rx_hdr_valid = 1'b0;
        last_src_ip  = src_ip;
        for (int i = 0; i < beats; i++) begin
            random_bits(64, data);
            random_bits(4, bits);
            rx_payload_data  = data;
            rx_payload_keep  = (i == beats - 1) ? (8'hFF >> bits[2:0]) : 8'hFF;
            rx_payload_user  = bits[3];
            rx_payload_last  = (i == beats - 1);
            rx_payload_valid = 1'b1;
            beat = {54'd0, rx_payload_user, rx_payload_last, rx_payload_keep, data};
            if (port == 16'd10001) begin
                exp_m00.push_back(beat);
            end else if (port == 16'd10000) begin
                exp_m01.push_back(beat);
            end
            if (i == stall_at) begin
                if (port == 16'd10000) begin
                    m01_ready = 1'b0;
                end else begin
                    m00_ready = 1'b0;
                end
                repeat (3) @(negedge clk);
                m00_ready = 1'b1;
                m01_ready = 1'b1;
            end
            wait_handshake(1, "rx payload beat");
        end
        rx_payload_valid = 1'b0;
    endtask

    // channel 0 also holds the header off for two cycles
    // stall_at picks a beat that waits 2 cycles on tx_payload_ready, -1 for none
    task automatic send_tx_frame(input logic [1:0] chan, input int beats,
                                 input int stall_at);
        logic [63:0] data;
        logic [63:0] bits;
        exp_tx_hdr.push_back({32'd0, port_for_channel(chan), port_for_channel(chan),
                              LOCAL_IP, last_src_ip});
        s00_channel  = chan;
        tx_hdr_ready = (chan != 2'd0);
        for (int i = 0; i < beats; i++) begin
            random_bits(64, data);
            random_bits(3, bits);
            s00_data  = data;
            s00_keep  = (i == beats - 1) ? (8'hFF >> bits[2:0]) : 8'hFF;
            s00_last  = (i == beats - 1);
            s00_valid = 1'b1;
            exp_tx_pay.push_back({55'd0, s00_last, s00_keep, data});
            if (!tx_hdr_ready) begin
                repeat (2) @(negedge clk);
                tx_hdr_ready = 1'b1;
            end
            if (i == stall_at) begin
                tx_payload_ready = 1'b0;
                repeat (2) @(negedge clk);
                tx_payload_ready = 1'b1;
            end
            wait_handshake(2, "user beat");
        end
        s00_valid = 1'b0;
    endtask

    // transfers seen by the DUT's neighbours, pre-edge values
    always @(posedge clk) begin
        if (!rst) begin
            if (m00_valid && m00_ready) begin
                check_beat("m00_{user,last,keep,data}", exp_m00,
                           {54'd0, m00_user, m00_last, m00_keep, m00_data});
            end
            if (m01_valid && m01_ready) begin
                check_beat("m01_{user,last,keep,data}", exp_m01,
                           {54'd0, m01_user, m01_last, m01_keep, m01_data});
            end
            if (tx_hdr_valid && tx_hdr_ready) begin
                check_beat("tx_{source_port,dest_port,source_ip,dest_ip}", exp_tx_hdr,
                           {32'd0, tx_source_port, tx_dest_port, tx_source_ip, tx_dest_ip});
            end
            if (tx_payload_valid && tx_payload_ready) begin
                check_beat("tx_payload_{last,keep,data}", exp_tx_pay,
                           {55'd0, tx_payload_last, tx_payload_keep, tx_payload_data});
            end
        end
    end

    // whole frame stalls while the rf sink holds off
    assert property (@(posedge clk) disable iff (rst)
        (m00_valid && !m00_ready) |-> !rx_payload_ready)
    else begin
        value_errors++;
        $display("error rx_payload_ready expected 0 got %0h", $sampled(rx_payload_ready));
    end

    // user held off while the header is offered
    assert property (@(posedge clk) disable iff (rst)
        tx_hdr_valid |-> !s00_ready)
    else begin
        value_errors++;
        $display("error s00_ready expected 0 got %0h", $sampled(s00_ready));
    end

    initial begin
        clk              = 1'b0;
        rst              = 1'b1;
        rx_hdr_valid     = 1'b0;
        rx_dest_port     = '0;
        rx_source_ip     = '0;
        rx_payload_data  = '0;
        rx_payload_keep  = '0;
        rx_payload_valid = 1'b0;
        rx_payload_last  = 1'b0;
        rx_payload_user  = 1'b0;
        m00_ready        = 1'b1;
        m01_ready        = 1'b1;
        s00_data         = '0;
        s00_keep         = '0;
        s00_valid        = 1'b0;
        s00_last         = 1'b0;
        s00_channel      = '0;
        tx_hdr_ready     = 1'b1;
        tx_payload_ready = 1'b1;
        cfg_wr_en        = 1'b0;
        cfg_addr         = '0;
        cfg_wr_data      = '0;
        lfsr             = 16'd16;
        last_src_ip      = '0;
        value_errors     = 0;
        timeouts         = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // register writes, the last one to an unused address
        cfg_wr_en   = 1'b1;
        cfg_addr    = 2'd0;
        cfg_wr_data = LOCAL_IP;
        @(negedge clk);
        check_value("local_ip", LOCAL_IP, local_ip);
        cfg_addr    = 2'd1;
        cfg_wr_data = GATEWAY_IP;
        @(negedge clk);
        check_value("gateway_ip", GATEWAY_IP, gateway_ip);
        cfg_addr    = 2'd3;
        cfg_wr_data = 32'hFFFF_FFFF;
        @(negedge clk);
        cfg_wr_en = 1'b0;
        check_value("local_ip", LOCAL_IP, local_ip);
        check_value("gateway_ip", GATEWAY_IP, gateway_ip);
        read_back(2'd0, LOCAL_IP);
        read_back(2'd1, GATEWAY_IP);
        read_back(2'd2, 32'd0);
        read_back(2'd3, 32'd0);

        // rf, ps, then a port nobody listens on
        send_rx_frame(16'd10001, 32'h0A00_0001, 3, -1);
        send_rx_frame(16'd10000, 32'h0A00_0002, 2, 1);
        send_rx_frame(16'd5000, 32'h0A00_0003, 2, -1);
        send_tx_frame(2'd0, 2, -1);
        send_tx_frame(2'd1, 3, 1);
        send_rx_frame(16'd10001, 32'h0A00_0004, 4, 2);
        send_tx_frame(2'd2, 1, -1);
        send_tx_frame(2'd3, 2, -1);

        repeat (3) @(negedge clk);
        report_leftover("m00", exp_m00.size());
        report_leftover("m01", exp_m01.size());
        report_leftover("tx header", exp_tx_hdr.size());
        report_leftover("tx payload", exp_tx_pay.size());
        $display("errors: %0d value, %0d timeout, %0d protocol",
                 value_errors, timeouts, dut0.asserts0.fail_count);
        if (value_errors == 0 && timeouts == 0 && dut0.asserts0.fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/udp_app_bridge_asserts.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stream protocol checks for the UDP application bridge
// valid held until ready, rf and ps never valid together
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module udp_app_bridge_asserts (
    input wire clk,
    input wire rst,
    input wire m00_valid,
    input wire m00_ready,
    input wire m01_valid,
    input wire m01_ready,
    input wire tx_hdr_valid,
    input wire tx_hdr_ready,
    input wire tx_payload_valid,
    input wire tx_payload_ready
);

    int fail_count;

    initial fail_count = 0;

    m00_hold: assert property (@(posedge clk) disable iff (rst)
        (m00_valid && !m00_ready) |=> m00_valid)
    else begin
        fail_count++;
        $error("m00_valid dropped before m00_ready");
    end

    m01_hold: assert property (@(posedge clk) disable iff (rst)
        (m01_valid && !m01_ready) |=> m01_valid)
    else begin
        fail_count++;
        $error("m01_valid dropped before m01_ready");
    end

    tx_hdr_hold: assert property (@(posedge clk) disable iff (rst)
        (tx_hdr_valid && !tx_hdr_ready) |=> tx_hdr_valid)
    else begin
        fail_count++;
        $error("tx_hdr_valid dropped before tx_hdr_ready");
    end

    tx_payload_hold: assert property (@(posedge clk) disable iff (rst)
        (tx_payload_valid && !tx_payload_ready) |=> tx_payload_valid)
    else begin
        fail_count++;
        $error("tx_payload_valid dropped before tx_payload_ready");
    end

    // one route per frame
    m_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(m00_valid && m01_valid))
    else begin
        fail_count++;
        $error("m00_valid and m01_valid high together");
    end

endmodule

bind udp_app_bridge udp_app_bridge_asserts asserts0 (
    .clk              (clk),
    .rst              (rst),
    .m00_valid        (m00_valid),
    .m00_ready        (m00_ready),
    .m01_valid        (m01_valid),
    .m01_ready        (m01_ready),
    .tx_hdr_valid     (tx_hdr_valid),
    .tx_hdr_ready     (tx_hdr_ready),
    .tx_payload_valid (tx_payload_valid),
    .tx_payload_ready (tx_payload_ready)
);

`default_nettype wire

// ==== rtl/udp_app_bridge.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UDP application bridge, top level
// config registers, receive demux and transmit header generator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module udp_app_bridge (
    input  wire                       clk,
    input  wire                       rst,
    // receive header and payload from the stack
    input  wire                       rx_hdr_valid,
    output logic                      rx_hdr_ready,
    input  udp_bridge_pkg::udp_port_t rx_dest_port,
    input  udp_bridge_pkg::ip_addr_t  rx_source_ip,
    input  udp_bridge_pkg::data_t     rx_payload_data,
    input  udp_bridge_pkg::keep_t     rx_payload_keep,
    input  wire                       rx_payload_valid,
    output logic                      rx_payload_ready,
    input  wire                       rx_payload_last,
    input  wire                       rx_payload_user,
    // rf stream
    output udp_bridge_pkg::data_t     m00_data,
    output udp_bridge_pkg::keep_t     m00_keep,
    output logic                      m00_valid,
    input  wire                       m00_ready,
    output logic                      m00_last,
    output logic                      m00_user,
    // ps stream
    output udp_bridge_pkg::data_t     m01_data,
    output udp_bridge_pkg::keep_t     m01_keep,
    output logic                      m01_valid,
    input  wire                       m01_ready,
    output logic                      m01_last,
    output logic                      m01_user,
    // user transmit stream
    input  udp_bridge_pkg::data_t     s00_data,
    input  udp_bridge_pkg::keep_t     s00_keep,
    input  wire                       s00_valid,
    output logic                      s00_ready,
    input  wire                       s00_last,
    input  udp_bridge_pkg::channel_t  s00_channel,
    // transmit header and payload to the stack
    output logic                      tx_hdr_valid,
    input  wire                       tx_hdr_ready,
    output udp_bridge_pkg::udp_port_t tx_source_port,
    output udp_bridge_pkg::udp_port_t tx_dest_port,
    output udp_bridge_pkg::ip_addr_t  tx_source_ip,
    output udp_bridge_pkg::ip_addr_t  tx_dest_ip,
    output udp_bridge_pkg::data_t     tx_payload_data,
    output udp_bridge_pkg::keep_t     tx_payload_keep,
    output logic                      tx_payload_valid,
    input  wire                       tx_payload_ready,
    output logic                      tx_payload_last,
    // host register port
    input  wire                       cfg_wr_en,
    input  udp_bridge_pkg::reg_addr_t cfg_addr,
    input  udp_bridge_pkg::reg_data_t cfg_wr_data,
    output udp_bridge_pkg::reg_data_t cfg_rd_data,
    // addressing for the stack
    output udp_bridge_pkg::ip_addr_t  local_ip,
    output udp_bridge_pkg::ip_addr_t  gateway_ip
);

    // last sender, reply target for transmit
    udp_bridge_pkg::ip_addr_t peer_ip;

    cfg_regs cfg_regs0 (
        .clk         (clk),
        .rst         (rst),
        .cfg_wr_en   (cfg_wr_en),
        .cfg_addr    (cfg_addr),
        .cfg_wr_data (cfg_wr_data),
        .cfg_rd_data (cfg_rd_data),
        .local_ip    (local_ip),
        .gateway_ip  (gateway_ip)
    );

    udp_rx_demux rx_demux0 (
        .clk              (clk),
        .rst              (rst),
        .rx_hdr_valid     (rx_hdr_valid),
        .rx_hdr_ready     (rx_hdr_ready),
        .rx_dest_port     (rx_dest_port),
        .rx_source_ip     (rx_source_ip),
        .rx_payload_data  (rx_payload_data),
        .rx_payload_keep  (rx_payload_keep),
        .rx_payload_valid (rx_payload_valid),
        .rx_payload_ready (rx_payload_ready),
        .rx_payload_last  (rx_payload_last),
        .rx_payload_user  (rx_payload_user),
        .m00_data         (m00_data),
        .m00_keep         (m00_keep),
        .m00_valid        (m00_valid),
        .m00_ready        (m00_ready),
        .m00_last         (m00_last),
        .m00_user         (m00_user),
        .m01_data         (m01_data),
        .m01_keep         (m01_keep),
        .m01_valid        (m01_valid),
        .m01_ready        (m01_ready),
        .m01_last         (m01_last),
        .m01_user         (m01_user),
        .peer_ip          (peer_ip)
    );

    udp_tx_header tx_header0 (
        .clk              (clk),
        .rst              (rst),
        .s00_data         (s00_data),
        .s00_keep         (s00_keep),
        .s00_valid        (s00_valid),
        .s00_ready        (s00_ready),
        .s00_last         (s00_last),
        .s00_channel      (s00_channel),
        .local_ip         (local_ip),
        .peer_ip          (peer_ip),
        .tx_hdr_valid     (tx_hdr_valid),
        .tx_hdr_ready     (tx_hdr_ready),
        .tx_source_port   (tx_source_port),
        .tx_dest_port     (tx_dest_port),
        .tx_source_ip     (tx_source_ip),
        .tx_dest_ip       (tx_dest_ip),
        .tx_payload_data  (tx_payload_data),
        .tx_payload_keep  (tx_payload_keep),
        .tx_payload_valid (tx_payload_valid),
        .tx_payload_ready (tx_payload_ready),
        .tx_payload_last  (tx_payload_last)
    );

endmodule

`default_nettype wire

// ==== tx/udp_tx_header.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// transmit header generator toward the UDP stack
// one header per user frame, then payload pass-through
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module udp_tx_header (
    input  wire                       clk,
    input  wire                       rst,
    // user stream
    input  udp_bridge_pkg::data_t     s00_data,
    input  udp_bridge_pkg::keep_t     s00_keep,
    input  wire                       s00_valid,
    output logic                      s00_ready,
    input  wire                       s00_last,
    input  udp_bridge_pkg::channel_t  s00_channel,
    // addressing
    input  udp_bridge_pkg::ip_addr_t  local_ip,
    input  udp_bridge_pkg::ip_addr_t  peer_ip,
    // header to the stack
    output logic                      tx_hdr_valid,
    input  wire                       tx_hdr_ready,
    output udp_bridge_pkg::udp_port_t tx_source_port,
    output udp_bridge_pkg::udp_port_t tx_dest_port,
    output udp_bridge_pkg::ip_addr_t  tx_source_ip,
    output udp_bridge_pkg::ip_addr_t  tx_dest_ip,
    // payload to the stack
    output udp_bridge_pkg::data_t     tx_payload_data,
    output udp_bridge_pkg::keep_t     tx_payload_keep,
    output logic                      tx_payload_valid,
    input  wire                       tx_payload_ready,
    output logic                      tx_payload_last
);

    udp_bridge_pkg::tx_state_t state;

    logic in_hdr;
    logic hdr_xfer;
    logic last_xfer;

    assign in_hdr    = (state == udp_bridge_pkg::tx_hdr);
    assign hdr_xfer  = tx_hdr_valid && tx_hdr_ready;
    assign last_xfer = tx_payload_valid && tx_payload_ready && tx_payload_last;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= udp_bridge_pkg::tx_hdr;
        end else begin
            case (state)
                udp_bridge_pkg::tx_hdr: begin
                    if (hdr_xfer) begin
                        state <= udp_bridge_pkg::tx_payload;
                    end
                end
                default: begin
                    if (last_xfer) begin
                        state <= udp_bridge_pkg::tx_hdr;
                    end
                end
            endcase
        end
    end

    // header is offered while the first beat waits, user held off
    assign tx_hdr_valid = in_hdr && s00_valid;
    assign s00_ready    = !in_hdr && tx_payload_ready;

    // first beat's channel picks the port, reply goes to the same port
    assign tx_source_port = udp_bridge_pkg::CHANNEL_PORT[s00_channel];
    assign tx_dest_port   = tx_source_port;
    assign tx_source_ip   = local_ip;
    assign tx_dest_ip     = peer_ip;

    assign tx_payload_data  = s00_data;
    assign tx_payload_keep  = s00_keep;
    assign tx_payload_last  = s00_last;
    assign tx_payload_valid = !in_hdr && s00_valid;

endmodule

`default_nettype wire

// ==== rx/udp_rx_demux.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// receive demultiplexer for UDP frames from the stack
// steers by destination port to rf (m00), ps (m01) or drop
// latches the peer IP of each accepted header
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module udp_rx_demux (
    input  wire                       clk,
    input  wire                       rst,
    // header from the stack
    input  wire                       rx_hdr_valid,
    output logic                      rx_hdr_ready,
    input  udp_bridge_pkg::udp_port_t rx_dest_port,
    input  udp_bridge_pkg::ip_addr_t  rx_source_ip,
    // payload from the stack
    input  udp_bridge_pkg::data_t     rx_payload_data,
    input  udp_bridge_pkg::keep_t     rx_payload_keep,
    input  wire                       rx_payload_valid,
    output logic                      rx_payload_ready,
    input  wire                       rx_payload_last,
    input  wire                       rx_payload_user,
    // rf stream
    output udp_bridge_pkg::data_t     m00_data,
    output udp_bridge_pkg::keep_t     m00_keep,
    output logic                      m00_valid,
    input  wire                       m00_ready,
    output logic                      m00_last,
    output logic                      m00_user,
    // ps stream
    output udp_bridge_pkg::data_t     m01_data,
    output udp_bridge_pkg::keep_t     m01_keep,
    output logic                      m01_valid,
    input  wire                       m01_ready,
    output logic                      m01_last,
    output logic                      m01_user,
    // source IP of the most recent header
    output udp_bridge_pkg::ip_addr_t  peer_ip
);

    udp_bridge_pkg::route_t   route;
    udp_bridge_pkg::ip_addr_t peer_ip_q;

    logic hdr_xfer;
    logic last_xfer;

    assign rx_hdr_ready = (route == udp_bridge_pkg::route_idle);
    assign hdr_xfer     = rx_hdr_valid && rx_hdr_ready;
    assign last_xfer    = rx_payload_valid && rx_payload_ready && rx_payload_last;

    // route held for the whole frame
    always_ff @(posedge clk) begin
        if (rst) begin
            route     <= udp_bridge_pkg::route_idle;
            peer_ip_q <= '0;
        end else if (hdr_xfer) begin
            peer_ip_q <= rx_source_ip;
            if (rx_dest_port == udp_bridge_pkg::PORT_RF) begin
                route <= udp_bridge_pkg::route_rf;
            end else if (rx_dest_port == udp_bridge_pkg::PORT_PS) begin
                route <= udp_bridge_pkg::route_ps;
            end else begin
                route <= udp_bridge_pkg::route_drop;
            end
        end else if (last_xfer) begin
            route <= udp_bridge_pkg::route_idle;
        end
    end

    // ready back to the stack follows the selected sink
    always_comb begin
        case (route)
            udp_bridge_pkg::route_rf:   rx_payload_ready = m00_ready;
            udp_bridge_pkg::route_ps:   rx_payload_ready = m01_ready;
            udp_bridge_pkg::route_drop: rx_payload_ready = 1'b1;
            default:                    rx_payload_ready = 1'b0;
        endcase
    end

    // payload fans out to both, only valid is gated
    assign m00_data  = rx_payload_data;
    assign m00_keep  = rx_payload_keep;
    assign m00_last  = rx_payload_last;
    assign m00_user  = rx_payload_user;
    assign m00_valid = rx_payload_valid && (route == udp_bridge_pkg::route_rf);

    assign m01_data  = rx_payload_data;
    assign m01_keep  = rx_payload_keep;
    assign m01_last  = rx_payload_last;
    assign m01_user  = rx_payload_user;
    assign m01_valid = rx_payload_valid && (route == udp_bridge_pkg::route_ps);

    assign peer_ip = peer_ip_q;

endmodule

`default_nettype wire

// ==== rtl/cfg_regs.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// configuration registers for the UDP stack
// local and gateway IP, strobe write, registered read-back
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module cfg_regs (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       cfg_wr_en,
    input  udp_bridge_pkg::reg_addr_t cfg_addr,
    input  udp_bridge_pkg::reg_data_t cfg_wr_data,
    output udp_bridge_pkg::reg_data_t cfg_rd_data,
    output udp_bridge_pkg::ip_addr_t  local_ip,
    output udp_bridge_pkg::ip_addr_t  gateway_ip
);

    udp_bridge_pkg::ip_addr_t  local_ip_q;
    udp_bridge_pkg::ip_addr_t  gateway_ip_q;
    udp_bridge_pkg::reg_data_t rd_data_q;

    // write decode, other addresses fall through
    always_ff @(posedge clk) begin
        if (rst) begin
            local_ip_q   <= '0;
            gateway_ip_q <= '0;
        end else if (cfg_wr_en) begin
            case (cfg_addr)
                udp_bridge_pkg::REG_LOCAL_IP:   local_ip_q   <= cfg_wr_data;
                udp_bridge_pkg::REG_GATEWAY_IP: gateway_ip_q <= cfg_wr_data;
                default: ;
            endcase
        end
    end

    // read mux, one cycle after the address
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_data_q <= '0;
        end else begin
            case (cfg_addr)
                udp_bridge_pkg::REG_LOCAL_IP:   rd_data_q <= local_ip_q;
                udp_bridge_pkg::REG_GATEWAY_IP: rd_data_q <= gateway_ip_q;
                default:                        rd_data_q <= '0;
            endcase
        end
    end

    assign cfg_rd_data = rd_data_q;
    assign local_ip    = local_ip_q;
    assign gateway_ip  = gateway_ip_q;

endmodule

`default_nettype wire

// ==== common/udp_bridge_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types and constants for the UDP application bridge
// stream widths, port numbers, register map, state enums
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package udp_bridge_pkg;

    // payload stream widths
    localparam int DATA_W = 64;
    localparam int KEEP_W = DATA_W / 8;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [KEEP_W-1:0] keep_t;

    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;

    // channel code carried on the user transmit stream
    typedef logic [1:0] channel_t;

    // host register port
    typedef logic [1:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // receive steering for the frame in flight
    typedef enum logic [1:0] {
        route_idle,
        route_rf,
        route_ps,
        route_drop
    } route_t;

    // transmit side, header first then payload
    typedef enum logic {
        tx_hdr,
        tx_payload
    } tx_state_t;

    localparam udp_port_t PORT_PS  = 16'd10000;
    localparam udp_port_t PORT_RF  = 16'd10001;
    localparam udp_port_t PORT_AUX = 16'd10002;

    // channel code to UDP port, index 0 in the low slot
    // code 3 has no service and maps to port 0
    localparam logic [3:0][15:0] CHANNEL_PORT = {
        16'd0,
        PORT_AUX,
        PORT_RF,
        PORT_PS
    };

    // register map
    localparam reg_addr_t REG_LOCAL_IP   = 2'd0;
    localparam reg_addr_t REG_GATEWAY_IP = 2'd1;

endpackage

`default_nettype wire
